/* backend_defines.svh */
`ifndef BACKEND_DEFINES_SVH
`define BACKEND_DEFINES_SVH

//////////////////////////////////////////////////
// widths of the backend slice
//////////////////////////////////////////////////

// instruction slots accepted per cycle
`define FETCH_WIDTH 2
// entries leaving the queue per cycle
`define ISSUE_WIDTH 2

`define DQ_DEPTH 8
`define REG_COUNT 16
`define XLEN 32

// reorder index bits without the direction bit
`define ROB_WIDTH 4

`endif

/* backend_pkg.sv */
`include "backend_defines.svh"

package backend_pkg;

    typedef logic [`XLEN-1:0] data_t;
    typedef logic [3:0] reg_idx_t;
    typedef logic [31:0] inst_word_t;

    // dir flips each time idx wraps
    typedef struct packed {
        logic dir;
        logic [`ROB_WIDTH-1:0] idx;
    } rob_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL
    } alu_op_t;

    typedef struct packed {
        rob_idx_t rob;
        logic we;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        alu_op_t op;
        logic use_imm;
        logic [11:0] imm;
    } dis_status_t;

    typedef struct packed {
        logic valid;
        rob_idx_t rob;
        logic we;
        reg_idx_t rd;
        data_t value;
    } result_t;

endpackage

/* inst_decode.sv */
`include "backend_defines.svh"

module inst_decode import backend_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic [`FETCH_WIDTH-1:0] inst_valid_i,
    input  inst_word_t [`FETCH_WIDTH-1:0] inst_i,
    input  logic dq_full_i,
    input  logic redirect_i,
    input  rob_idx_t redirect_rob_i,
    output logic inst_ready_o,
    output logic [`FETCH_WIDTH-1:0] dis_valid_o,
    output dis_status_t [`FETCH_WIDTH-1:0] dis_status_o
);
    localparam int CNT_W = $clog2(`FETCH_WIDTH + 1);
    localparam int ROB_W = `ROB_WIDTH + 1;
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] F7_ZERO = 7'b0000000;
    localparam logic [6:0] F7_ALT = 7'b0100000;

    rob_idx_t next_rob;
    logic [CNT_W-1:0] rank [`FETCH_WIDTH];
    logic [CNT_W-1:0] add_cnt;
    logic accept;

    // unsupported encodings come out as a bubble with we low
    function automatic dis_status_t decode_one(input inst_word_t w);
        dis_status_t s;
        logic [6:0] opcode;
        logic [6:0] funct7;
        logic is_op;
        logic is_imm;
        logic ok;
        opcode = w[6:0];
        funct7 = w[31:25];
        is_op = opcode == OPC_OP;
        is_imm = opcode == OPC_OP_IMM;
        ok = 1'b0;
        s = '0;
        case (w[14:12])
            3'b000: begin
                if (is_imm || funct7 == F7_ZERO) begin
                    s.op = ALU_ADD;
                    ok = 1'b1;
                end else if (funct7 == F7_ALT) begin
                    s.op = ALU_SUB;
                    ok = 1'b1;
                end
            end
            3'b001: begin
                s.op = ALU_SLL;
                ok = funct7 == F7_ZERO;
            end
            3'b100: begin
                s.op = ALU_XOR;
                ok = is_imm || funct7 == F7_ZERO;
            end
            3'b101: begin
                s.op = ALU_SRL;
                ok = funct7 == F7_ZERO;
            end
            3'b110: begin
                s.op = ALU_OR;
                ok = is_imm || funct7 == F7_ZERO;
            end
            3'b111: begin
                s.op = ALU_AND;
                ok = is_imm || funct7 == F7_ZERO;
            end
            default: ok = 1'b0;
        endcase
        // rv32e has only x0..x15
        ok = ok && (is_op || is_imm) && !w[11] && !w[19] && (is_imm || !w[24]);
        if (ok) begin
            s.rd = w[10:7];
            s.rs1 = w[18:15];
            s.rs2 = is_imm ? 4'd0 : w[23:20];
            s.use_imm = is_imm;
            s.imm = is_imm ? w[31:20] : 12'd0;
            s.we = w[10:7] != 4'd0;
        end else begin
            s = '0;
        end
        return s;
    endfunction

    // rank of each slot among the valid ones
    always_comb begin
        add_cnt = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            rank[i] = add_cnt;
            add_cnt = add_cnt + CNT_W'(inst_valid_i[i]);
        end
    end

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            dis_status_o[i] = decode_one(inst_i[i]);
            dis_status_o[i].rob = rob_idx_t'(next_rob + ROB_W'(rank[i]));
        end
    end

    assign dis_valid_o = inst_valid_i;
    assign inst_ready_o = !dq_full_i;
    assign accept = !dq_full_i && !redirect_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            next_rob <= '0;
        end else if (redirect_i) begin
            next_rob <= rob_idx_t'(redirect_rob_i + 1'b1);
        end else if (accept) begin
            next_rob <= rob_idx_t'(next_rob + ROB_W'(add_cnt));
        end
    end

endmodule

/* dispatch_queue.sv */
`include "backend_defines.svh"

module dispatch_queue import backend_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic [`FETCH_WIDTH-1:0] dis_valid_i,
    input  dis_status_t [`FETCH_WIDTH-1:0] dis_status_i,
    input  logic issue_stall_i,
    input  logic redirect_i,
    input  rob_idx_t redirect_rob_i,
    output logic dq_full_o,
    output logic [`ISSUE_WIDTH-1:0] issue_valid_o,
    output dis_status_t [`ISSUE_WIDTH-1:0] issue_status_o
);
    localparam int AW = $clog2(`DQ_DEPTH);
    localparam int CNT_W = $clog2(`FETCH_WIDTH + 1);
    localparam int ISS_W = $clog2(`ISSUE_WIDTH + 1);

    dis_status_t ram [`DQ_DEPTH];
    logic [AW-1:0] head;
    logic [AW-1:0] tail;
    logic [AW:0] num;

    logic [CNT_W-1:0] rank [`FETCH_WIDTH];
    logic [CNT_W-1:0] add_cnt;
    logic [CNT_W-1:0] eq_num;
    logic [ISS_W-1:0] sub_num;
    logic enq;

    logic [`DQ_DEPTH-1:0] occ;
    logic [`DQ_DEPTH-1:0] older;
    logic [`DQ_DEPTH-1:0] keep;
    logic [`DQ_DEPTH-1:0] run_end;
    logic [AW:0] walk_num;
    logic [AW-1:0] walk_tail;
    logic keep_full;
    logic keep_empty;

    // direction bits decide the age order across a wrap
    function automatic logic is_older(input rob_idx_t a, input rob_idx_t b);
        return (a.dir ^ b.dir) ^ (a.idx < b.idx);
    endfunction

    //////////////////////////////////////////////////
    // enqueue
    //////////////////////////////////////////////////

    always_comb begin
        add_cnt = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            rank[i] = add_cnt;
            add_cnt = add_cnt + CNT_W'(dis_valid_i[i]);
        end
    end

    assign dq_full_o = (num + add_cnt) > `DQ_DEPTH;
    assign enq = !dq_full_o && !redirect_i;
    assign eq_num = enq ? add_cnt : '0;

    always_ff @(posedge clk) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (enq && dis_valid_i[i]) begin
                ram[tail + AW'(rank[i])] <= dis_status_i[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // issue from head
    //////////////////////////////////////////////////

    always_comb begin
        sub_num = '0;
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            issue_valid_o[k] = (num > k) && !issue_stall_i && !redirect_i;
            issue_status_o[k] = ram[head + AW'(k)];
            sub_num = sub_num + ISS_W'(issue_valid_o[k]);
        end
    end

    //////////////////////////////////////////////////
    // redirect walk
    //////////////////////////////////////////////////

    for (genvar i = 0; i < `DQ_DEPTH; i++) begin : g_walk
        logic [AW-1:0] off;
        assign off = AW'(i) - head;
        assign occ[i] = {1'b0, off} < num;
        assign older[i] = is_older(ram[i].rob, redirect_rob_i);
        // last kept entry before a gap
        assign run_end[i] = keep[i] && !keep[(i + 1) % `DQ_DEPTH];
    end

    assign keep = occ & older;
    assign keep_full = &keep;
    assign keep_empty = ~|keep;

    always_comb begin
        walk_num = '0;
        walk_tail = head;
        for (int i = 0; i < `DQ_DEPTH; i++) begin
            walk_num = walk_num + (AW + 1)'(keep[i]);
            if (run_end[i]) begin
                walk_tail = AW'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head <= '0;
            tail <= '0;
            num <= '0;
        end else if (redirect_i) begin
            if (keep_empty) begin
                tail <= head;
            end else if (!keep_full) begin
                tail <= walk_tail + 1'b1;
            end
            num <= walk_num;
        end else begin
            head <= head + AW'(sub_num);
            tail <= tail + AW'(eq_num);
            num <= num + (AW + 1)'(eq_num) - (AW + 1)'(sub_num);
        end
    end

endmodule

/* alu_execute.sv */
`include "backend_defines.svh"

module alu_execute import backend_pkg::*; (
    input  logic [`ISSUE_WIDTH-1:0] issue_valid_i,
    input  dis_status_t [`ISSUE_WIDTH-1:0] issue_status_i,
    input  data_t [2*`ISSUE_WIDTH-1:0] rd_data_i,
    output reg_idx_t [2*`ISSUE_WIDTH-1:0] rd_addr_o,
    output result_t [`ISSUE_WIDTH-1:0] exe_result_o
);

    function automatic data_t alu(input alu_op_t op, input data_t a, input data_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return a + b;
        endcase
    endfunction

    always_comb begin
        data_t src_a;
        data_t src_b;
        data_t imm_ext;
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            rd_addr_o[2*k] = issue_status_i[k].rs1;
            rd_addr_o[2*k+1] = issue_status_i[k].rs2;
            src_a = rd_data_i[2*k];
            src_b = rd_data_i[2*k+1];
            // younger lanes see results of older lanes in the same cycle
            for (int j = 0; j < k; j++) begin
                if (exe_result_o[j].valid && exe_result_o[j].we) begin
                    if (exe_result_o[j].rd == issue_status_i[k].rs1) begin
                        src_a = exe_result_o[j].value;
                    end
                    if (exe_result_o[j].rd == issue_status_i[k].rs2) begin
                        src_b = exe_result_o[j].value;
                    end
                end
            end
            imm_ext = {{(`XLEN-12){issue_status_i[k].imm[11]}}, issue_status_i[k].imm};
            if (issue_status_i[k].use_imm) begin
                src_b = imm_ext;
            end
            exe_result_o[k].valid = issue_valid_i[k];
            exe_result_o[k].rob = issue_status_i[k].rob;
            exe_result_o[k].we = issue_status_i[k].we;
            exe_result_o[k].rd = issue_status_i[k].rd;
            exe_result_o[k].value = alu(issue_status_i[k].op, src_a, src_b);
        end
    end

endmodule

/* writeback_regfile.sv */
`include "backend_defines.svh"

module writeback_regfile import backend_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  reg_idx_t [2*`ISSUE_WIDTH-1:0] rd_addr_i,
    input  result_t [`ISSUE_WIDTH-1:0] exe_result_i,
    output data_t [2*`ISSUE_WIDTH-1:0] rd_data_o,
    output result_t [`ISSUE_WIDTH-1:0] result_o
);

    data_t regs [`REG_COUNT];
    logic [`ISSUE_WIDTH-1:0] res_valid_q;
    result_t [`ISSUE_WIDTH-1:0] res_q;

    //////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////

    // x0 is hardwired to zero
    for (genvar p = 0; p < 2*`ISSUE_WIDTH; p++) begin : g_read
        assign rd_data_o[p] = (rd_addr_i[p] == '0) ? '0 : regs[rd_addr_i[p]];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // later lane is younger and wins
            for (int k = 0; k < `ISSUE_WIDTH; k++) begin
                if (exe_result_i[k].valid && exe_result_i[k].we &&
                    exe_result_i[k].rd != '0) begin
                    regs[exe_result_i[k].rd] <= exe_result_i[k].value;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // result port
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            res_valid_q <= '0;
        end else begin
            for (int k = 0; k < `ISSUE_WIDTH; k++) begin
                res_valid_q[k] <= exe_result_i[k].valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        res_q <= exe_result_i;
    end

    always_comb begin
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            result_o[k] = res_q[k];
            result_o[k].valid = res_valid_q[k];
        end
    end

endmodule

/* backend_top.sv */
`include "backend_defines.svh"

module backend_top import backend_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic [`FETCH_WIDTH-1:0] inst_valid_i,
    input  inst_word_t [`FETCH_WIDTH-1:0] inst_i,
    input  logic issue_stall_i,
    input  logic redirect_i,
    input  rob_idx_t redirect_rob_i,
    output logic inst_ready_o,
    output result_t [`ISSUE_WIDTH-1:0] result_o
);

    logic [`FETCH_WIDTH-1:0] dis_valid;
    dis_status_t [`FETCH_WIDTH-1:0] dis_status;
    logic dq_full;
    logic [`ISSUE_WIDTH-1:0] issue_valid;
    dis_status_t [`ISSUE_WIDTH-1:0] issue_status;
    reg_idx_t [2*`ISSUE_WIDTH-1:0] rd_addr;
    data_t [2*`ISSUE_WIDTH-1:0] rd_data;
    result_t [`ISSUE_WIDTH-1:0] exe_result;

    inst_decode i_decode (
        .clk            (clk),
        .rst            (rst),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .dq_full_i      (dq_full),
        .redirect_i     (redirect_i),
        .redirect_rob_i (redirect_rob_i),
        .inst_ready_o   (inst_ready_o),
        .dis_valid_o    (dis_valid),
        .dis_status_o   (dis_status)
    );

    dispatch_queue i_queue (
        .clk            (clk),
        .rst            (rst),
        .dis_valid_i    (dis_valid),
        .dis_status_i   (dis_status),
        .issue_stall_i  (issue_stall_i),
        .redirect_i     (redirect_i),
        .redirect_rob_i (redirect_rob_i),
        .dq_full_o      (dq_full),
        .issue_valid_o  (issue_valid),
        .issue_status_o (issue_status)
    );

    alu_execute i_execute (
        .issue_valid_i  (issue_valid),
        .issue_status_i (issue_status),
        .rd_data_i      (rd_data),
        .rd_addr_o      (rd_addr),
        .exe_result_o   (exe_result)
    );

    writeback_regfile i_writeback (
        .clk            (clk),
        .rst            (rst),
        .rd_addr_i      (rd_addr),
        .exe_result_i   (exe_result),
        .rd_data_o      (rd_data),
        .result_o       (result_o)
    );

endmodule

/* tb_backend.sv */
`include "backend_defines.svh"

module tb_backend import backend_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        rob_idx_t rob;
        inst_word_t w;
    } exp_t;

    logic clk;
    logic rst;
    logic [`FETCH_WIDTH-1:0] inst_valid_i;
    inst_word_t [`FETCH_WIDTH-1:0] inst_i;
    logic issue_stall_i;
    logic redirect_i;
    rob_idx_t redirect_rob_i;
    logic inst_ready_o;
    result_t [`ISSUE_WIDTH-1:0] result_o;

    exp_t exp_q[$];
    data_t mregs [`REG_COUNT];
    rob_idx_t mnext;
    int errors;
    int cycles;
    int ready_low;
    logic bp_check;

    backend_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .issue_stall_i  (issue_stall_i),
        .redirect_i     (redirect_i),
        .redirect_rob_i (redirect_rob_i),
        .inst_ready_o   (inst_ready_o),
        .result_o       (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (exp === got) else begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected=%h actual=%h", $time, name, exp, got);
        end
    endtask

    // a is older than b in reorder order
    function automatic logic is_before(input rob_idx_t a, input rob_idx_t b);
        if (a.dir == b.dir) begin
            return a.idx < b.idx;
        end
        return a.idx > b.idx;
    endfunction

    // sequential reference for one instruction against the model registers
    function automatic void model_exec(input inst_word_t w, output logic we,
                                       output reg_idx_t rd, output data_t val);
        logic is_imm;
        logic legal;
        logic ok;
        logic [6:0] f7;
        data_t a;
        data_t b;
        is_imm = w[6:0] == 7'h13;
        f7 = w[31:25];
        legal = ((w[6:0] == 7'h33 && !w[24]) || is_imm) && !w[11] && !w[19];
        a = mregs[w[18:15]];
        b = is_imm ? {{20{w[31]}}, w[31:20]} : mregs[w[23:20]];
        ok = 1'b0;
        val = '0;
        case (w[14:12])
            3'd0: begin
                ok = is_imm || f7 == 7'h00 || f7 == 7'h20;
                val = (!is_imm && f7 == 7'h20) ? a - b : a + b;
            end
            3'd1: begin
                ok = f7 == 7'h00;
                val = a << b[4:0];
            end
            3'd4: begin
                ok = is_imm || f7 == 7'h00;
                val = a ^ b;
            end
            3'd5: begin
                ok = f7 == 7'h00;
                val = a >> b[4:0];
            end
            3'd6: begin
                ok = is_imm || f7 == 7'h00;
                val = a | b;
            end
            3'd7: begin
                ok = is_imm || f7 == 7'h00;
                val = a & b;
            end
            default: ok = 1'b0;
        endcase
        ok = ok && legal;
        we = ok && w[10:7] != 4'd0;
        rd = ok ? w[10:7] : 4'd0;
    endfunction

    // mostly legal encodings on a few registers so lanes depend on each other
    function automatic inst_word_t gen_inst();
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [11:0] hi;
        int kind;
        kind = $urandom % 16;
        if (kind == 0) begin
            return $urandom;
        end
        opc = ($urandom % 2) ? 7'h33 : 7'h13;
        f3 = 3'($urandom);
        f7 = ($urandom % 4 == 0) ? 7'h20 : 7'h00;
        if (kind == 1) begin
            f7 = 7'($urandom);
        end
        rd = (kind == 2) ? 5'($urandom) : 5'($urandom % 8);
        rs1 = 5'($urandom % 8);
        if (opc == 7'h33) begin
            hi = {f7, 5'($urandom % 8)};
        end else if (f3 == 3'd1 || f3 == 3'd5) begin
            hi = {f7, 5'($urandom)};
        end else begin
            hi = 12'($urandom);
        end
        return {hi, rs1, f3, rd, opc};
    endfunction

    task automatic check_result(input result_t r);
        exp_t e;
        logic we;
        reg_idx_t rd;
        data_t val;
        if (exp_q.size() == 0) begin
            errors++;
            $display("result for rob %h appeared with no instruction pending", r.rob);
            return;
        end
        e = exp_q.pop_front();
        model_exec(e.w, we, rd, val);
        check_eq("result_o.rob", 32'(e.rob), 32'(r.rob));
        check_eq("result_o.we", 32'(we), 32'(r.we));
        check_eq("result_o.rd", 32'(rd), 32'(r.rd));
        if (we) begin
            check_eq("result_o.value", val, r.value);
            mregs[rd] = val;
        end
    endtask

    // only entries strictly older than the redirect index survive
    task automatic apply_redirect(input rob_idx_t r);
        exp_t kept[$];
        foreach (exp_q[i]) begin
            if (is_before(exp_q[i].rob, r)) begin
                kept.push_back(exp_q[i]);
            end
        end
        exp_q = kept;
        mnext = rob_idx_t'(r + 5'd1);
    endtask

    //////////////////////////////////////////////////
    // monitor and model
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            if (bp_check) begin
                check_eq("inst_ready_o",
                         32'(exp_q.size() + $countones(inst_valid_i) <= `DQ_DEPTH),
                         32'(inst_ready_o));
                if (!inst_ready_o) begin
                    ready_low++;
                end
            end
            for (int k = 0; k < `ISSUE_WIDTH; k++) begin
                if (result_o[k].valid) begin
                    check_result(result_o[k]);
                end
            end
            if (redirect_i) begin
                apply_redirect(redirect_rob_i);
            end else if (inst_ready_o) begin
                for (int i = 0; i < `FETCH_WIDTH; i++) begin
                    if (inst_valid_i[i]) begin
                        exp_q.push_back('{rob: mnext, w: inst_i[i]});
                        mnext = rob_idx_t'(mnext + 5'd1);
                    end
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        ($past(issue_stall_i) || $past(redirect_i)) |-> !(result_o[0].valid || result_o[1].valid))
    else begin
        errors++;
        $display("CHECK FAILED t=%0t result_o.valid expected=0 actual=%b", $time,
                 {result_o[1].valid, result_o[0].valid});
    end

    // lane 1 never carries a result without lane 0
    assert property (@(posedge clk) disable iff (!rst) result_o[1].valid |-> result_o[0].valid)
    else begin
        errors++;
        $display("CHECK FAILED t=%0t result_o[0].valid expected=1 actual=0", $time);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= 4000) begin
            $display("timeout: the run did not finish within 4000 cycles, errors: %0d", errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic drive_slots(input logic [`FETCH_WIDTH-1:0] mask);
        inst_valid_i <= mask;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            inst_i[i] <= gen_inst();
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 200) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d instructions never produced a result", exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic latency_test();
        int n;
        wait_drain();
        @(posedge clk);
        drive_slots(2'b01);
        @(posedge clk);
        check_eq("inst_ready_o", 32'd1, 32'(inst_ready_o));
        inst_valid_i <= '0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!result_o[0].valid && n < 10);
        check_eq("result latency", 32'd2, 32'(n));
    endtask

    task automatic random_traffic(input int n);
        repeat (n) begin
            @(posedge clk);
            drive_slots(2'($urandom));
            issue_stall_i <= ($urandom % 8 == 0);
        end
        @(posedge clk);
        inst_valid_i <= '0;
        issue_stall_i <= 1'b0;
        wait_drain();
    endtask

    task automatic backpressure_test();
        wait_drain();
        @(posedge clk);
        issue_stall_i <= 1'b1;
        ready_low = 0;
        bp_check <= 1'b1;
        repeat (20) begin
            @(posedge clk);
            drive_slots(2'b11);
        end
        @(posedge clk);
        bp_check <= 1'b0;
        inst_valid_i <= '0;
        issue_stall_i <= 1'b0;
        wait_drain();
        if (ready_low == 0) begin
            errors++;
            $display("inst_ready_o never fell while the queue was stalled");
        end
    endtask

    task automatic redirect_test(input int pos);
        wait_drain();
        @(posedge clk);
        issue_stall_i <= 1'b1;
        repeat (4) begin
            @(posedge clk);
            drive_slots(2'b11);
        end
        @(posedge clk);
        inst_valid_i <= '0;
        repeat (2) @(posedge clk);
        check_eq("queued entries", 32'(`DQ_DEPTH), 32'(exp_q.size()));
        @(posedge clk);
        redirect_i <= 1'b1;
        redirect_rob_i <= exp_q[pos].rob;
        @(posedge clk);
        redirect_i <= 1'b0;
        issue_stall_i <= 1'b0;
        drive_slots(2'b01);
        @(posedge clk);
        inst_valid_i <= '0;
        wait_drain();
    endtask

    initial begin
        void'($urandom(19553));
        errors = 0;
        cycles = 0;
        ready_low = 0;
        bp_check = 1'b0;
        mnext = '0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            mregs[r] = '0;
        end
        rst = 1'b0;
        inst_valid_i = '0;
        inst_i = '0;
        issue_stall_i = 1'b0;
        redirect_i = 1'b0;
        redirect_rob_i = '0;
        repeat (5) @(posedge clk);
        check_eq("inst_ready_o in reset", 32'd1, 32'(inst_ready_o));
        check_eq("result_o.valid in reset", 32'd0, 32'({result_o[1].valid, result_o[0].valid}));
        rst <= 1'b1;
        latency_test();
        random_traffic(400);
        backpressure_test();
        redirect_test(3);
        random_traffic(100);
        redirect_test(5);
        random_traffic(200);
        repeat (4) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
backend_pkg.sv
inst_decode.sv
dispatch_queue.sv
alu_execute.sv
writeback_regfile.sv
backend_top.sv
tb_backend.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output

verilator --binary --timing --assert -Wno-fatal --top-module tb_backend \
    -f filelist.f -o tb_backend \
    && out="$(./obj_dir/tb_backend)" \
    && echo "$out" \
    && echo "$out" | grep -qx "PASS: all tests" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
